/* filelist.f */
hw/lm_video_pkg.sv
hw/lm_regs_pkg.sv
hw/lm_apb_regs.sv
hw/lm_line_writer.sv
hw/lm_line_buffer.sv
hw/lm_line_reader.sv
hw/lm_scanline.sv
hw/linedoubler_top.sv
sim/tb_clk_gen.sv
sim/linedoubler_props.sv
sim/tb_linedoubler.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_linedoubler
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Finished with errors

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "RESULT: FAIL"; exit 1; \
	else echo "RESULT: PASS"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_linedoubler.sv */
// video stops between table rows so each configuration starts from an idle pipeline
`timescale 1ns/100ps

module tb_linedoubler;

  import lm_video_pkg::*;
  import lm_regs_pkg::*;

  localparam int H_TOTAL   = H_TOTAL_DEF;
  localparam int H_START   = H_START_DEF;
  localparam int H_ACTIVE  = H_ACTIVE_DEF;
  localparam int HS_WIDTH  = HS_WIDTH_DEF;
  localparam int HS_IN_PIX = 3;            // input nHS low for 3 pixels, 6 clocks
  localparam int NUM_ROWS  = 6;
  localparam int TIMEOUT   = 8 * H_TOTAL;  // clocks
  localparam int CW        = COLOR_W_I;

  typedef struct packed {
    logic       enable;
    logic       sl_en;
    logic       sl_id;
    logic [7:0] sl_str;
    logic [3:0] lines;
    logic [3:0] hs_falls;   // expected nhs_o falls over the row
  } row_t;

  logic                  VCLK_o, nVRST_o;
  logic                  vdata_valid, nhs, nvs;
  logic [CW-1:0]         r, g, b;
  logic                  psel, penable, pwrite, pready;
  logic [APB_ADDR_W-1:0] paddr;
  logic [APB_DATA_W-1:0] pwdata, prdata;
  logic                  nhs_out, nvs_out, data_valid;
  logic [COLOR_W_O-1:0]  r_out, g_out, b_out;

  row_t          rows [NUM_ROWS];
  logic [31:0]   rng_q;
  logic [3*CW-1:0] stored [H_ACTIVE];   // window of the last input line
  logic [23:0]   exp_q [$];              // expected {r, g, b} in output order
  logic [23:0]   exp_pix;
  bit            model_primed, cur_enable;
  logic          nhs_prev;
  logic          nvs_prev;
  int            run_len, hs_falls, err_cnt;
  int            vs_falls, vs_low;

  tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(2)) i_tb_clk_gen (
    .VCLK_o  (VCLK_o),
    .nVRST_o (nVRST_o)
  );

  linedoubler_top #(
    .H_TOTAL  (H_TOTAL),
    .H_START  (H_START),
    .H_ACTIVE (H_ACTIVE),
    .HS_WIDTH (HS_WIDTH)
  ) i_linedoubler_top (
    .VCLK_o        (VCLK_o),
    .nVRST_o       (nVRST_o),
    .vdata_valid_i (vdata_valid),
    .nhs_i         (nhs),
    .nvs_i         (nvs),
    .r_i           (r),
    .g_i           (g),
    .b_i           (b),
    .psel_i        (psel),
    .penable_i     (penable),
    .pwrite_i      (pwrite),
    .paddr_i       (paddr),
    .pwdata_i      (pwdata),
    .prdata_o      (prdata),
    .pready_o      (pready),
    .nhs_o         (nhs_out),
    .nvs_o         (nvs_out),
    .data_valid_o  (data_valid),
    .r_o           (r_out),
    .g_o           (g_out),
    .b_o           (b_out)
  );

  //////////////////////////////////////////////////////////////////////////
  // reference model

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // MSB copied below the LSB, then darkened by (256 - str) / 256
  function automatic logic [7:0] out_color(input logic [CW-1:0] c, input bit dim,
                                           input logic [7:0] str);
    int w;
    w = int'(c) * 2 + (int'(c) >> (CW - 1));
    if (dim) begin
      w = (w * (256 - int'(str))) / 256;
    end
    return 8'(w);
  endfunction

  function automatic logic [23:0] out_pixel(input logic [3*CW-1:0] pix, input bit dim,
                                            input logic [7:0] str);
    return {out_color(pix[3*CW-1:2*CW], dim, str), out_color(pix[2*CW-1:CW], dim, str),
            out_color(pix[CW-1:0], dim, str)};
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // checks

  task automatic report_failure(input string what);
    err_cnt++;
    $display("ERROR: %s at %0t ns", what, $time);
    $display("Finished with errors");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // APB master

  task automatic apb_access(input bit wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int n;
    @(posedge VCLK_o);
    psel    <= 1'b1;   // setup phase
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge VCLK_o);
    penable <= 1'b1;
    n = 0;
    @(negedge VCLK_o);
    while (!pready && n < TIMEOUT) begin
      @(negedge VCLK_o);
      n++;
    end
    if (!pready) begin
      report_failure("APB slave never raised pready_o");
    end
    rdata = prdata;    // valid in the access phase
    @(posedge VCLK_o);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic write_config(input row_t row);
    reg_word_u   w;
    logic [31:0] rd;
    w = '0;
    w.ctrl.enable = row.enable;
    apb_access(1'b1, ADDR_CTRL, w, rd);
    w = '0;
    w.sl.sl_en  = row.sl_en;
    w.sl.sl_id  = row.sl_id;
    w.sl.sl_str = row.sl_str;
    apb_access(1'b1, ADDR_SL, w, rd);
    apb_access(1'b1, 8'h08, 32'hffff_ffff, rd);   // unmapped, must be ignored
    apb_access(1'b0, ADDR_CTRL, '0, rd);
    check_value("prdata_o (CTRL)", rd, {31'b0, row.enable});
    apb_access(1'b0, ADDR_SL, '0, rd);
    check_value("prdata_o (SL)", rd, {16'b0, row.sl_str, 6'b0, row.sl_id, row.sl_en});
    apb_access(1'b0, 8'h08, '0, rd);
    check_value("prdata_o (0x08)", rd, 32'h0);
    apb_access(1'b0, 8'hfc, '0, rd);
    check_value("prdata_o (0xfc)", rd, 32'h0);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // video source

  task automatic send_line(input row_t row, input bit vsync);
    logic [3*CW-1:0] pix;
    // the stored line comes out twice while this one is written
    if (row.enable) begin
      if (model_primed) begin
        for (int copy = 0; copy < 2; copy++) begin
          for (int i = 0; i < H_ACTIVE; i++) begin
            exp_q.push_back(out_pixel(stored[i], row.sl_en && (copy == row.sl_id),
                                      row.sl_str));
          end
        end
      end
      model_primed = 1'b1;
    end
    for (int p = 0; p < H_TOTAL; p++) begin
      rng_q = xorshift32(rng_q);
      pix   = rng_q[3*CW-1:0];
      @(posedge VCLK_o);
      vdata_valid <= 1'b1;
      nhs         <= (p >= HS_IN_PIX);
      nvs         <= !vsync;   // nVS low over the whole line
      {r, g, b}   <= pix;
      if (p >= H_START && p < H_START + H_ACTIVE) begin
        stored[p - H_START] = pix;
        if (!row.enable) begin
          exp_q.push_back(out_pixel(pix, 1'b0, 8'h00));   // bypass, plain widening
        end
      end
      @(posedge VCLK_o);
      vdata_valid <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < TIMEOUT) begin
      @(negedge VCLK_o);
      n++;
    end
    if (exp_q.size() != 0) begin
      report_failure($sformatf("%0d expected pixels never came out", exp_q.size()));
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // output monitor, samples on the falling edge

  always @(negedge VCLK_o) begin
    if (nVRST_o) begin
      if (nhs_prev && !nhs_out) begin
        hs_falls++;
      end
      nhs_prev = nhs_out;
      if (nvs_prev && !nvs_out) begin
        vs_falls++;
      end
      if (!nvs_out) begin
        vs_low++;
      end
      nvs_prev = nvs_out;
      if (data_valid) begin
        run_len++;
        if (exp_q.size() == 0) begin
          report_failure("valid output pixel that no input line accounts for");
        end else begin
          exp_pix = exp_q.pop_front();
          check_value("r_o", r_out, exp_pix[23:16]);
          check_value("g_o", g_out, exp_pix[15:8]);
          check_value("b_o", b_out, exp_pix[7:0]);
        end
      end else if (run_len != 0) begin
        if (cur_enable) begin
          check_value("data_valid_o run length", run_len, H_ACTIVE);
        end
        run_len = 0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int n;
    vdata_valid  = 1'b0;
    nhs          = 1'b1;
    nvs          = 1'b1;
    r            = '0;
    g            = '0;
    b            = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    rng_q        = 32'd99885;
    model_primed = 1'b0;
    cur_enable   = 1'b0;
    nhs_prev     = 1'b1;
    nvs_prev     = 1'b1;
    run_len      = 0;
    hs_falls     = 0;
    vs_falls     = 0;
    vs_low       = 0;
    err_cnt      = 0;

    //        enable sl_en sl_id sl_str lines falls
    rows[0] = '{1'b1, 1'b0, 1'b0, 8'h00, 4'd4, 4'd6};   // first line only primes
    rows[1] = '{1'b1, 1'b1, 1'b0, 8'h40, 4'd3, 4'd6};   // still primed from row 0
    rows[2] = '{1'b1, 1'b1, 1'b1, 8'hff, 4'd3, 4'd6};
    rows[3] = '{1'b0, 1'b1, 1'b0, 8'h80, 4'd3, 4'd3};   // bypass
    rows[4] = '{1'b1, 1'b1, 1'b1, 8'h80, 4'd3, 4'd4};   // primes again
    rows[5] = '{1'b1, 1'b1, 1'b0, 8'h00, 4'd2, 4'd4};

    n = 0;
    while (!nVRST_o && n < TIMEOUT) begin
      @(negedge VCLK_o);
      n++;
    end
    if (!nVRST_o) begin
      report_failure("reset was never released");
    end

    for (int i = 0; i < NUM_ROWS; i++) begin
      write_config(rows[i]);
      if (!rows[i].enable) begin
        model_primed = 1'b0;
      end
      cur_enable = rows[i].enable;
      hs_falls   = 0;
      vs_falls   = 0;
      vs_low     = 0;
      for (int l = 0; l < rows[i].lines; l++) begin
        send_line(rows[i], l == 0);
      end
      wait_drain();
      repeat (H_TOTAL) @(posedge VCLK_o);   // idle gap, video stopped
      check_value("nhs_o falls per row", hs_falls, rows[i].hs_falls);
      // nVS of the first input line covers two output lines, or one input line in bypass
      check_value("nvs_o falls per row", vs_falls, 1);
      check_value("nvs_o low clocks per row", vs_low, 2 * H_TOTAL);
    end

    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* sim/linedoubler_props.sv */
// bound into linedoubler_top; nHS width is only checked while doubling is enabled
`timescale 1ns/100ps

module linedoubler_props #(
  parameter int HS_WIDTH = lm_video_pkg::HS_WIDTH_DEF
) (
  input logic VCLK_o,
  input logic nVRST_o,
  input logic enable_i,
  input logic pready_i,
  input logic nhs_i,
  input logic data_valid_i
);

  // APB slave has no wait states
  a_pready_high: assert property (@(posedge VCLK_o) disable iff (!nVRST_o) pready_i)
    else $error("pready_o dropped low");

  // every output nHS pulse is HS_WIDTH clocks long
  a_hs_width: assert property (@(posedge VCLK_o) disable iff (!nVRST_o || !enable_i)
    $fell(nhs_i) |-> (!nhs_i) [*HS_WIDTH] ##1 nhs_i)
    else $error("nhs_o low pulse is not %0d clocks", HS_WIDTH);

  a_valid_known: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    !$isunknown(data_valid_i))
    else $error("data_valid_o is unknown");

endmodule

bind linedoubler_top linedoubler_props #(.HS_WIDTH(HS_WIDTH)) i_linedoubler_props (
  .VCLK_o       (VCLK_o),
  .nVRST_o      (nVRST_o),
  .enable_i     (enable),
  .pready_i     (pready_o),
  .nhs_i        (nhs_o),
  .data_valid_i (data_valid_o)
);

/* sim/tb_clk_gen.sv */
// testbench clock and reset; reset is released on a rising edge after RST_CYCLES clocks
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2
) (
  output logic VCLK_o,
  output logic nVRST_o
);

  initial begin
    VCLK_o = 1'b0;
    forever #(PERIOD_NS / 2) VCLK_o = ~VCLK_o;
  end

  initial begin
    nVRST_o = 1'b0;
    repeat (RST_CYCLES) @(posedge VCLK_o);
    nVRST_o <= 1'b1;   // released together with the DUT inputs
  end

endmodule

/* hw/linedoubler_top.sv */
// line doubler top; single clock, one input pixel every 2nd clock, doubling starts disabled
`timescale 1ns/100ps

module linedoubler_top #(
  parameter int H_TOTAL  = lm_video_pkg::H_TOTAL_DEF,
  parameter int H_START  = lm_video_pkg::H_START_DEF,
  parameter int H_ACTIVE = lm_video_pkg::H_ACTIVE_DEF,
  parameter int HS_WIDTH = lm_video_pkg::HS_WIDTH_DEF
) (
  input  logic                                VCLK_o,
  input  logic                                nVRST_o,
  // video in
  input  logic                                vdata_valid_i,
  input  logic                                nhs_i,
  input  logic                                nvs_i,
  input  logic [lm_video_pkg::COLOR_W_I-1:0]  r_i,
  input  logic [lm_video_pkg::COLOR_W_I-1:0]  g_i,
  input  logic [lm_video_pkg::COLOR_W_I-1:0]  b_i,
  // APB slave
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [lm_regs_pkg::APB_ADDR_W-1:0]  paddr_i,
  input  logic [lm_regs_pkg::APB_DATA_W-1:0]  pwdata_i,
  output logic [lm_regs_pkg::APB_DATA_W-1:0]  prdata_o,
  output logic                                pready_o,
  // video out
  output logic                                nhs_o,
  output logic                                nvs_o,
  output logic                                data_valid_o,
  output logic [lm_video_pkg::COLOR_W_O-1:0]  r_o,
  output logic [lm_video_pkg::COLOR_W_O-1:0]  g_o,
  output logic [lm_video_pkg::COLOR_W_O-1:0]  b_o
);

  import lm_video_pkg::*;

  logic                   enable, sl_en, sl_id;
  logic [7:0]             sl_str;
  logic                   wr_en, wr_page, line_start;
  logic [BUF_ADDR_W-1:0]  wr_addr, rd_addr;
  logic [3*COLOR_W_I-1:0] wr_data, rd_data;
  logic                   rd_en, rd_page;
  logic                   rd_nhs, rd_nvs, rd_valid, rd_dim;

  lm_apb_regs i_lm_apb_regs (
    .VCLK_o    (VCLK_o),
    .nVRST_o   (nVRST_o),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .enable_o  (enable),
    .sl_en_o   (sl_en),
    .sl_id_o   (sl_id),
    .sl_str_o  (sl_str)
  );

  lm_line_writer #(.H_START(H_START), .H_ACTIVE(H_ACTIVE)) i_lm_line_writer (
    .VCLK_o        (VCLK_o),
    .nVRST_o       (nVRST_o),
    .vdata_valid_i (vdata_valid_i),
    .nhs_i         (nhs_i),
    .r_i           (r_i),
    .g_i           (g_i),
    .b_i           (b_i),
    .wr_en_o       (wr_en),
    .wr_page_o     (wr_page),
    .wr_addr_o     (wr_addr),
    .wr_data_o     (wr_data),
    .line_start_o  (line_start)
  );

  lm_line_buffer i_lm_line_buffer (
    .VCLK_o    (VCLK_o),
    .wr_en_i   (wr_en),
    .wr_page_i (wr_page),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .rd_en_i   (rd_en),
    .rd_page_i (rd_page),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  lm_line_reader #(
    .H_TOTAL  (H_TOTAL),
    .H_ACTIVE (H_ACTIVE),
    .HS_WIDTH (HS_WIDTH)
  ) i_lm_line_reader (
    .VCLK_o       (VCLK_o),
    .nVRST_o      (nVRST_o),
    .enable_i     (enable),
    .line_start_i (line_start),
    .nvs_i        (nvs_i),
    .wr_page_i    (wr_page),
    .sl_en_i      (sl_en),
    .sl_id_i      (sl_id),
    .rd_en_o      (rd_en),
    .rd_page_o    (rd_page),
    .rd_addr_o    (rd_addr),
    .nhs_o        (rd_nhs),
    .nvs_o        (rd_nvs),
    .valid_o      (rd_valid),
    .dim_o        (rd_dim)
  );

  // bypass takes the writer's registered window pixels
  lm_scanline i_lm_scanline (
    .VCLK_o       (VCLK_o),
    .nVRST_o      (nVRST_o),
    .enable_i     (enable),
    .sl_str_i     (sl_str),
    .rd_data_i    (rd_data),
    .valid_i      (rd_valid),
    .dim_i        (rd_dim),
    .nhs_i        (rd_nhs),
    .nvs_i        (rd_nvs),
    .byp_valid_i  (wr_en),
    .byp_nhs_i    (nhs_i),
    .byp_nvs_i    (nvs_i),
    .byp_r_i      (wr_data[3*COLOR_W_I-1:2*COLOR_W_I]),
    .byp_g_i      (wr_data[2*COLOR_W_I-1:COLOR_W_I]),
    .byp_b_i      (wr_data[COLOR_W_I-1:0]),
    .nhs_o        (nhs_o),
    .nvs_o        (nvs_o),
    .data_valid_o (data_valid_o),
    .r_o          (r_o),
    .g_o          (g_o),
    .b_o          (b_o)
  );

endmodule

/* hw/lm_scanline.sv */
// two register stages; bypass pixels come from the writer, so bypass sync is registered twice too
`timescale 1ns/100ps

module lm_scanline (
  input  logic                                  VCLK_o,
  input  logic                                  nVRST_o,
  input  logic                                  enable_i,
  input  logic [7:0]                            sl_str_i,
  input  logic [3*lm_video_pkg::COLOR_W_I-1:0]  rd_data_i,
  input  logic                                  valid_i,
  input  logic                                  dim_i,
  input  logic                                  nhs_i,
  input  logic                                  nvs_i,
  input  logic                                  byp_valid_i,
  input  logic                                  byp_nhs_i,
  input  logic                                  byp_nvs_i,
  input  logic [lm_video_pkg::COLOR_W_I-1:0]    byp_r_i,
  input  logic [lm_video_pkg::COLOR_W_I-1:0]    byp_g_i,
  input  logic [lm_video_pkg::COLOR_W_I-1:0]    byp_b_i,
  output logic                                  nhs_o,
  output logic                                  nvs_o,
  output logic                                  data_valid_o,
  output logic [lm_video_pkg::COLOR_W_O-1:0]    r_o,
  output logic [lm_video_pkg::COLOR_W_O-1:0]    g_o,
  output logic [lm_video_pkg::COLOR_W_O-1:0]    b_o
);

  import lm_video_pkg::*;

  // widen to the output width and optionally scale by k/256
  function automatic logic [COLOR_W_O-1:0] shade(input logic [COLOR_W_I-1:0] c,
                                                 input logic dim,
                                                 input logic [8:0] k);
    logic [COLOR_W_O-1:0] w;
    logic [COLOR_W_O+8:0] p;
    w = {c, c[COLOR_W_I-1]};
    p = w * k;
    return dim ? p[COLOR_W_O+7:8] : w;
  endfunction

  logic [8:0]           k;            // 256 - strength, 1..256
  logic [COLOR_W_I-1:0] rd_r, rd_g, rd_b;
  logic                 valid_q, nhs_q, nvs_q;
  logic                 byp_nhs_q, byp_nvs_q;
  logic [COLOR_W_O-1:0] r_q, g_q, b_q;

  assign k = 9'd256 - {1'b0, sl_str_i};
  assign {rd_r, rd_g, rd_b} = rd_data_i;

  ////////////////////////////////////////////////////////////////////////////
  // control: stage 1 and output registers

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      valid_q      <= 1'b0;
      nhs_q        <= 1'b1;
      nvs_q        <= 1'b1;
      byp_nhs_q    <= 1'b1;
      byp_nvs_q    <= 1'b1;
      data_valid_o <= 1'b0;
      nhs_o        <= 1'b1;
      nvs_o        <= 1'b1;
    end else begin
      valid_q   <= valid_i;
      nhs_q     <= nhs_i;
      nvs_q     <= nvs_i;
      byp_nhs_q <= byp_nhs_i;
      byp_nvs_q <= byp_nvs_i;
      if (enable_i) begin
        data_valid_o <= valid_q;
        nhs_o        <= nhs_q;
        nvs_o        <= nvs_q;
      end else begin
        data_valid_o <= byp_valid_i;   // writer window, already registered once
        nhs_o        <= byp_nhs_q;
        nvs_o        <= byp_nvs_q;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pixel path

  always_ff @(posedge VCLK_o) begin
    r_q <= valid_i ? shade(rd_r, dim_i, k) : '0;
    g_q <= valid_i ? shade(rd_g, dim_i, k) : '0;
    b_q <= valid_i ? shade(rd_b, dim_i, k) : '0;
    if (enable_i) begin
      r_o <= r_q;
      g_o <= g_q;
      b_o <= b_q;
    end else begin
      r_o <= byp_valid_i ? shade(byp_r_i, 1'b0, k) : '0;   // plain widening
      g_o <= byp_valid_i ? shade(byp_g_i, 1'b0, k) : '0;
      b_o <= byp_valid_i ? shade(byp_b_i, 1'b0, k) : '0;
    end
  end

endmodule

/* hw/lm_line_reader.sv */
// needs HS_WIDTH < H_TOTAL and H_ACTIVE <= 2**BUF_ADDR_W; the input line must last 2*H_TOTAL clocks
`timescale 1ns/100ps

module lm_line_reader #(
  parameter int H_TOTAL  = lm_video_pkg::H_TOTAL_DEF,
  parameter int H_ACTIVE = lm_video_pkg::H_ACTIVE_DEF,
  parameter int HS_WIDTH = lm_video_pkg::HS_WIDTH_DEF
) (
  input  logic                                 VCLK_o,
  input  logic                                 nVRST_o,
  input  logic                                 enable_i,
  input  logic                                 line_start_i,
  input  logic                                 nvs_i,
  input  logic                                 wr_page_i,
  input  logic                                 sl_en_i,
  input  logic                                 sl_id_i,
  output logic                                 rd_en_o,
  output logic                                 rd_page_o,
  output logic [lm_video_pkg::BUF_ADDR_W-1:0]  rd_addr_o,
  output logic                                 nhs_o,
  output logic                                 nvs_o,
  output logic                                 valid_o,
  output logic                                 dim_o
);

  import lm_video_pkg::*;

  localparam int COL_W = $clog2(H_TOTAL);

  logic             primed_q;    // one line is in the buffer
  logic             running_q;
  logic             copy_q;      // output line 0 or 1 of the pair
  logic             page_q;
  logic             nvs_s_q;     // nVS sampled at the output line start
  logic [COL_W-1:0] col_q;
  logic             nhs_raw;
  logic             dim_raw;
  logic [3:0]       dly_q [RD_LATENCY];   // {nhs, nvs, valid, dim}

  ////////////////////////////////////////////////////////////////////////////
  // output column and copy counters

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      primed_q  <= 1'b0;
      running_q <= 1'b0;
      copy_q    <= 1'b0;
      page_q    <= 1'b0;
      nvs_s_q   <= 1'b1;
      col_q     <= '0;
    end else if (!enable_i) begin
      primed_q  <= 1'b0;   // re-enabling needs a fresh priming line
      running_q <= 1'b0;
    end else if (line_start_i) begin
      primed_q  <= 1'b1;
      running_q <= primed_q;
      copy_q    <= 1'b0;
      page_q    <= ~wr_page_i;  // writer has just flipped to the other page
      nvs_s_q   <= nvs_i;
      col_q     <= '0;
    end else if (running_q) begin
      if (col_q == COL_W'(H_TOTAL - 1)) begin
        col_q     <= '0;
        copy_q    <= ~copy_q;
        running_q <= ~copy_q;     // second copy ends the pair
        if (!copy_q) begin
          nvs_s_q <= nvs_i;
        end
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  assign rd_en_o   = running_q & (col_q < H_ACTIVE);
  assign rd_page_o = page_q;
  assign rd_addr_o = BUF_ADDR_W'(col_q);

  assign nhs_raw = ~(running_q & (col_q < HS_WIDTH));
  assign dim_raw = running_q & sl_en_i & (copy_q == sl_id_i);

  ////////////////////////////////////////////////////////////////////////////
  // align control with the buffer data, the scanline stage adds the rest

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      for (int i = 0; i < RD_LATENCY; i++) begin
        dly_q[i] <= 4'b1100;   // syncs idle high
      end
    end else begin
      dly_q[0] <= {nhs_raw, nvs_s_q, rd_en_o, dim_raw};
      for (int i = 1; i < RD_LATENCY; i++) begin
        dly_q[i] <= dly_q[i-1];
      end
    end
  end

  assign {nhs_o, nvs_o, valid_o, dim_o} = dly_q[RD_LATENCY-1];

endmodule

/* hw/lm_line_buffer.sv */
// two pages of pixel memory, no reset; read data appears RD_LATENCY clocks after rd_en_i
`timescale 1ns/100ps

module lm_line_buffer (
  input  logic                                  VCLK_o,
  input  logic                                  wr_en_i,
  input  logic                                  wr_page_i,
  input  logic [lm_video_pkg::BUF_ADDR_W-1:0]   wr_addr_i,
  input  logic [3*lm_video_pkg::COLOR_W_I-1:0]  wr_data_i,
  input  logic                                  rd_en_i,
  input  logic                                  rd_page_i,
  input  logic [lm_video_pkg::BUF_ADDR_W-1:0]   rd_addr_i,
  output logic [3*lm_video_pkg::COLOR_W_I-1:0]  rd_data_o
);

  import lm_video_pkg::*;

  localparam int DW    = 3 * COLOR_W_I;
  localparam int DEPTH = 2 ** (BUF_ADDR_W + 1);

  logic [DW-1:0] mem_q   [DEPTH];
  logic [DW-1:0] rd_pipe [RD_LATENCY];   // [0] is the memory output register

  always_ff @(posedge VCLK_o) begin
    if (wr_en_i) begin
      mem_q[{wr_page_i, wr_addr_i}] <= wr_data_i;
    end
    if (rd_en_i) begin
      rd_pipe[0] <= mem_q[{rd_page_i, rd_addr_i}];
    end
    for (int i = 1; i < RD_LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_data_o = rd_pipe[RD_LATENCY-1];

endmodule

/* hw/lm_line_writer.sv */
// pixel 0 of a line is the valid pixel that carries the nHS fall; H_START+H_ACTIVE <= 2**BUF_ADDR_W
`timescale 1ns/100ps

module lm_line_writer #(
  parameter int H_START  = lm_video_pkg::H_START_DEF,
  parameter int H_ACTIVE = lm_video_pkg::H_ACTIVE_DEF
) (
  input  logic                                  VCLK_o,
  input  logic                                  nVRST_o,
  input  logic                                  vdata_valid_i,
  input  logic                                  nhs_i,
  input  logic [lm_video_pkg::COLOR_W_I-1:0]    r_i,
  input  logic [lm_video_pkg::COLOR_W_I-1:0]    g_i,
  input  logic [lm_video_pkg::COLOR_W_I-1:0]    b_i,
  output logic                                  wr_en_o,
  output logic                                  wr_page_o,
  output logic [lm_video_pkg::BUF_ADDR_W-1:0]   wr_addr_o,
  output logic [3*lm_video_pkg::COLOR_W_I-1:0]  wr_data_o,
  output logic                                  line_start_o
);

  import lm_video_pkg::*;

  localparam int H_END = H_START + H_ACTIVE;
  localparam int CNT_W = $clog2(H_END + 1);

  logic             nhs_q;     // nHS of the previous valid pixel
  logic [CNT_W-1:0] hcnt_q;    // index of the next valid pixel
  logic             hs_fall;
  logic [CNT_W-1:0] pix_idx;
  logic             in_win;

  assign hs_fall = vdata_valid_i & nhs_q & ~nhs_i;
  assign pix_idx = hs_fall ? '0 : hcnt_q;
  assign in_win  = vdata_valid_i & (pix_idx >= H_START) & (pix_idx < H_END);

  ////////////////////////////////////////////////////////////////////////////
  // line timing and page toggle

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      nhs_q        <= 1'b1;
      hcnt_q       <= CNT_W'(H_END);  // no writes before the first line start
      wr_page_o    <= 1'b0;
      wr_en_o      <= 1'b0;
      line_start_o <= 1'b0;
    end else begin
      line_start_o <= hs_fall;
      wr_en_o      <= in_win;
      if (vdata_valid_i) begin
        nhs_q <= nhs_i;
      end
      if (hs_fall) begin
        hcnt_q    <= CNT_W'(1);
        wr_page_o <= ~wr_page_o;   // new line goes to the other page
      end else if (vdata_valid_i && hcnt_q != CNT_W'(H_END)) begin
        hcnt_q <= hcnt_q + 1'b1;   // saturates past the window
      end
    end
  end

  // write address and data, no reset needed
  always_ff @(posedge VCLK_o) begin
    wr_addr_o <= BUF_ADDR_W'(pix_idx - H_START);
    wr_data_o <= {r_i, g_i, b_i};
  end

endmodule

/* hw/lm_apb_regs.sv */
// APB slave without wait states; unmapped offsets read as zero and ignore writes
`timescale 1ns/100ps

module lm_apb_regs (
  input  logic                                VCLK_o,
  input  logic                                nVRST_o,
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [lm_regs_pkg::APB_ADDR_W-1:0]  paddr_i,
  input  lm_regs_pkg::reg_word_u              pwdata_i,
  output logic [lm_regs_pkg::APB_DATA_W-1:0]  prdata_o,
  output logic                                pready_o,
  output logic                                enable_o,
  output logic                                sl_en_o,
  output logic                                sl_id_o,
  output logic [7:0]                          sl_str_o
);

  import lm_regs_pkg::*;

  ctrl_reg_t ctrl_q;
  sl_reg_t   sl_q;
  logic      wr_acc;

  assign pready_o = 1'b1;
  assign wr_acc   = psel_i & penable_i & pwrite_i;  // access phase of a write

  // only the defined fields are stored, reserved bits stay zero
  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      ctrl_q <= '0;
      sl_q   <= '0;
    end else if (wr_acc) begin
      if (paddr_i == ADDR_CTRL) begin
        ctrl_q.enable <= pwdata_i.ctrl.enable;
      end
      if (paddr_i == ADDR_SL) begin
        sl_q.sl_en  <= pwdata_i.sl.sl_en;
        sl_q.sl_id  <= pwdata_i.sl.sl_id;
        sl_q.sl_str <= pwdata_i.sl.sl_str;
      end
    end
  end

  // readback is combinational, valid in the access phase
  always_comb begin
    case (paddr_i)
      ADDR_CTRL: prdata_o = ctrl_q;
      ADDR_SL:   prdata_o = sl_q;
      default:   prdata_o = '0;
    endcase
  end

  assign enable_o = ctrl_q.enable;
  assign sl_en_o  = sl_q.sl_en;
  assign sl_id_o  = sl_q.sl_id;
  assign sl_str_o = sl_q.sl_str;

endmodule

/* hw/lm_regs_pkg.sv */
// APB register map of the doubler; 8 bit byte addresses, 32 bit data, reserved bits read 0
package lm_regs_pkg;

  parameter int APB_ADDR_W = 8;
  parameter int APB_DATA_W = 32;

  // register offsets
  parameter logic [APB_ADDR_W-1:0] ADDR_CTRL = 8'h00;
  parameter logic [APB_ADDR_W-1:0] ADDR_SL   = 8'h04;

  // control register
  typedef struct packed {
    logic [30:0] rsvd;
    logic        enable;   // 1 = line doubling, 0 = bypass
  } ctrl_reg_t;

  // scanline register
  typedef struct packed {
    logic [15:0] rsvd_hi;
    logic [7:0]  sl_str;   // darkening strength, 0 = none
    logic [5:0]  rsvd_lo;
    logic        sl_id;    // copy that gets darkened
    logic        sl_en;
  } sl_reg_t;

  // one APB data word, seen as either register depending on the address
  typedef union packed {
    ctrl_reg_t ctrl;
    sl_reg_t   sl;
  } reg_word_u;

endpackage

/* hw/lm_video_pkg.sv */
// video widths, buffer geometry and default line timing; input pixels arrive every 2nd clock
package lm_video_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // colour widths

  parameter int COLOR_W_I = 7;   // per colour at the input
  parameter int COLOR_W_O = 8;   // input MSB is repeated as the new LSB

  ////////////////////////////////////////////////////////////////////////////
  // default input line timing, counted in input pixels

  parameter int H_TOTAL_DEF  = 64;  // pixels per line
  parameter int H_START_DEF  = 8;   // first active pixel, pixel 0 comes with the nHS fall
  parameter int H_ACTIVE_DEF = 48;  // active pixels per line

  // output nHS low time in clock cycles
  parameter int HS_WIDTH_DEF = 6;

  ////////////////////////////////////////////////////////////////////////////
  // line buffer

  parameter int BUF_ADDR_W = 6;   // one page holds 2**BUF_ADDR_W pixels
  parameter int RD_LATENCY = 2;   // read address to read data

endpackage
